//--- source/awm_defs.svh
// Data width must be a power of two of at least 32 bits; the byte count is limited to 20 bits
`ifndef AWM_DEFS_SVH
`define AWM_DEFS_SVH

// Address and data paths
`define AWM_ADDR_WIDTH 32
`define AWM_DATA_WIDTH 32

// Width of the transfer byte count
`define AWM_XFER_WIDTH 20

// Entries in the stream-to-W buffer
`define AWM_FIFO_DEPTH 32

// Protocol limits for one AXI4 burst
`define AWM_MAX_BURST_BYTES 4096
`define AWM_MAX_BURST_BEATS 256

// Addresses allowed in flight without a response
`define AWM_MAX_OUTSTANDING 8

`endif

//--- source/awm_pkg.sv
// All widths follow awm_defs.svh; the derived constants assume the byte count spans more than one burst
`include "awm_defs.svh"

package awm_pkg;

  // Bytes per beat and the burst length that fits both protocol limits
  localparam int beat_bytes = `AWM_DATA_WIDTH / 8;
  localparam int beat_bytes_log = $clog2(beat_bytes);
  localparam int burst_beats =
      (`AWM_MAX_BURST_BYTES / beat_bytes < `AWM_MAX_BURST_BEATS) ?
      `AWM_MAX_BURST_BYTES / beat_bytes : `AWM_MAX_BURST_BEATS;
  localparam int burst_bytes = burst_beats * beat_bytes;
  localparam int burst_beats_log = $clog2(burst_beats);

  // Total beats minus one, split into burst count and beat index
  localparam int total_beats_width = `AWM_XFER_WIDTH - beat_bytes_log;
  localparam int txn_cnt_width = total_beats_width - burst_beats_log;

  typedef logic [`AWM_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AWM_DATA_WIDTH-1:0] data_t;
  typedef logic [beat_bytes-1:0] strb_t;
  typedef logic [`AWM_XFER_WIDTH-1:0] xfer_bytes_t;
  typedef logic [burst_beats_log-1:0] beat_cnt_t;
  typedef logic [txn_cnt_width-1:0] txn_cnt_t;
  typedef logic [$clog2(`AWM_MAX_OUTSTANDING+1)-1:0] outst_cnt_t;
  // Extra top bit tells full from empty
  typedef logic [$clog2(`AWM_FIFO_DEPTH):0] fifo_ptr_t;

endpackage

//--- source/awm_plan_if.sv
// Fields are valid from the start pulse until the next start; only one driver, the request stage
interface awm_plan_if;

  // One-cycle pulse that launches the channel stages
  logic start;

  // Burst-aligned first address
  awm_pkg::addr_t base_addr;

  // Bursts after the first one, so zero means a single burst
  awm_pkg::txn_cnt_t num_txn;

  // Length of the last burst, in awlen form
  awm_pkg::beat_cnt_t final_len;
  logic single_txn;

  // Byte enables of the very last beat
  awm_pkg::strb_t final_strb;

  modport source (
    output start, base_addr, num_txn, final_len, single_txn, final_strb
  );

  modport sink (
    input start, base_addr, num_txn, final_len, single_txn, final_strb
  );

endinterface

//--- source/awm_counter.sv
// Load wins over incr and decr; incr and decr together hold the count; callers must not step below zero
module awm_counter #(
  parameter int width = 8,
  parameter logic [width-1:0] reset_value = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic [width-1:0] count,
  output logic             is_zero
);

  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= reset_value;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  // Zero flag straight off the register
  assign is_zero = (count == '0);

  // A lone decrement never hits an empty count
  a_no_underflow: assert property (
    @(posedge aclk) disable iff (areset)
    (decr && !incr && !load) |-> !is_zero
  );

endmodule

//--- source/awm_request.sv
// A zero byte count is not supported; the offset is forced down to a burst boundary
module awm_request (
  input  logic                  aclk,
  input  logic                  ctrl_start,
  input  awm_pkg::addr_t        ctrl_addr_offset,
  input  awm_pkg::xfer_bytes_t  ctrl_xfer_bytes,
  awm_plan_if.source            plan
);

  localparam int bb_log = awm_pkg::beat_bytes_log;
  localparam int len_width = awm_pkg::total_beats_width;
  localparam int beat_log = awm_pkg::burst_beats_log;
  localparam int txn_width = awm_pkg::txn_cnt_width;
  localparam awm_pkg::addr_t addr_mask = awm_pkg::addr_t'(awm_pkg::burst_bytes - 1);

  logic start_d1;
  // Total beats minus one
  logic [len_width-1:0] total_len_r;
  // Bytes used in a partial last beat, zero when the last beat is full
  logic [bb_log-1:0] remainder_r;
  logic [len_width-1:0] whole_beats;

  assign whole_beats = ctrl_xfer_bytes[bb_log +: len_width];

  ////////////////////////////////////////////////////////////
  // Stage 1: sample the request
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    start_d1 <= ctrl_start;
    if (ctrl_start) begin
      plan.base_addr <= ctrl_addr_offset & ~addr_mask;
      remainder_r <= ctrl_xfer_bytes[bb_log-1:0];
      // Round up to whole beats, minus one
      total_len_r <= (ctrl_xfer_bytes[bb_log-1:0] != '0) ? whole_beats : whole_beats - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: derive the burst plan
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    plan.start <= start_d1;
    plan.num_txn <= total_len_r[beat_log +: txn_width];
    plan.final_len <= total_len_r[beat_log-1:0];
    plan.single_txn <= (total_len_r[beat_log +: txn_width] == '0);
    // Bytes below the remainder, or every byte for a full last beat
    for (int i = 0; i < awm_pkg::beat_bytes; i++) begin
      plan.final_strb[i] <= (remainder_r == '0) || (i < remainder_r);
    end
  end

endmodule

//--- source/awm_data_fifo.sv
// Depth must be a power of two; push while full and pop while empty are illegal
`include "awm_defs.svh"

module awm_data_fifo (
  input  logic           aclk,
  input  logic           areset,
  input  logic           push,
  input  awm_pkg::data_t push_data,
  output logic           full,
  input  logic           pop,
  output logic           pop_valid,
  output awm_pkg::data_t pop_data
);

  localparam int idx_width = $clog2(`AWM_FIFO_DEPTH);

  awm_pkg::data_t mem [`AWM_FIFO_DEPTH];
  awm_pkg::fifo_ptr_t wr_ptr;
  awm_pkg::fifo_ptr_t rd_ptr;
  logic empty;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr[idx_width-1:0]] <= push_data;
    end
  end

  // Head word shows without a read strobe
  assign pop_data = mem[rd_ptr[idx_width-1:0]];

  ////////////////////////////////////////////////////////////
  // Pointers and flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign empty = (wr_ptr == rd_ptr);
  // Same slot, opposite lap
  assign full = (wr_ptr[idx_width] != rd_ptr[idx_width]) &&
                (wr_ptr[idx_width-1:0] == rd_ptr[idx_width-1:0]);
  assign pop_valid = !empty;

  a_no_overflow: assert property (
    @(posedge aclk) disable iff (areset) push |-> !full
  );

  a_no_underflow: assert property (
    @(posedge aclk) disable iff (areset) pop |-> pop_valid
  );

endmodule

//--- source/awm_wdata_channel.sv
// Beats leave only between start and the final beat; wvalid follows the buffer head while running
module awm_wdata_channel (
  input  logic           aclk,
  input  logic           areset,
  awm_plan_if.sink       plan,
  input  logic           buf_valid,
  input  awm_pkg::data_t buf_data,
  output logic           buf_pop,
  output logic           wvalid,
  input  logic           wready,
  output awm_pkg::data_t wdata,
  output awm_pkg::strb_t wstrb,
  output logic           wlast,
  output logic           first_pulse
);

  logic running;
  logic wxfer;
  logic final_txn;
  logic almost_final_txn;
  logic final_beat;
  logic load_beats;
  awm_pkg::beat_cnt_t beats_load_value;
  awm_pkg::txn_cnt_t txns_to_go;
  logic wfirst;
  logic first_seen;

  ////////////////////////////////////////////////////////////
  // Handshake gating
  ////////////////////////////////////////////////////////////
  assign wvalid = buf_valid & running;
  assign wdata = buf_data;
  assign buf_pop = buf_valid & running & wready;
  assign wxfer = wvalid & wready;

  assign final_beat = wlast & final_txn;
  // Full strobes except on the very last beat
  assign wstrb = final_beat ? plan.final_strb : '1;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (plan.start) begin
      running <= 1'b1;
    end else if (wxfer && final_beat) begin
      running <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Beat and burst counters
  ////////////////////////////////////////////////////////////
  // Reload on start and after every wlast, short length for the last burst
  assign load_beats = plan.start | (wxfer & wlast);
  always_comb begin
    if (plan.start) begin
      beats_load_value = plan.single_txn ? plan.final_len : '1;
    end else begin
      beats_load_value = almost_final_txn ? plan.final_len : '1;
    end
  end

  awm_counter #(
    .width       ($bits(awm_pkg::beat_cnt_t)),
    .reset_value ('1)
  ) i_beat_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load_beats),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (beats_load_value),
    .count      (),
    .is_zero    (wlast)
  );

  awm_counter #(
    .width       ($bits(awm_pkg::txn_cnt_t)),
    .reset_value ('0)
  ) i_txn_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (wxfer & wlast & ~final_txn),
    .load_value (plan.num_txn),
    .count      (txns_to_go),
    .is_zero    (final_txn)
  );

  assign almost_final_txn = (txns_to_go == awm_pkg::txn_cnt_t'(1));

  ////////////////////////////////////////////////////////////
  // First beat marker for the address stage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst <= 1'b1;
      first_seen <= 1'b0;
      first_pulse <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= wlast;
      end
      // Remember a first beat still waiting for wready
      first_seen <= wvalid & wfirst & ~wxfer;
      first_pulse <= wvalid & wfirst & ~first_seen;
    end
  end

endmodule

//--- source/awm_addr_channel.sv
// One address per burst, only after that burst's first beat shows on W; stall holds new requests
module awm_addr_channel (
  input  logic           aclk,
  input  logic           areset,
  awm_plan_if.sink       plan,
  input  logic           first_pulse,
  input  logic           stall,
  output logic           awvalid,
  input  logic           awready,
  output awm_pkg::addr_t awaddr,
  output logic [7:0]     awlen,
  output logic           aw_fire
);

  logic idle;
  logic final_txn;

  assign aw_fire = awvalid & awready;

  ////////////////////////////////////////////////////////////
  // Request generation
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid <= 1'b0;
    end else if (!awvalid) begin
      // Need a burst with data started and room for another address
      awvalid <= ~idle & ~stall;
    end else if (awready) begin
      awvalid <= 1'b0;
    end
  end

  // Address steps one full burst per accepted request
  always_ff @(posedge aclk) begin
    if (plan.start) begin
      awaddr <= plan.base_addr;
    end else if (aw_fire) begin
      awaddr <= awaddr + awm_pkg::burst_bytes;
    end
  end

  // Single burst is also the final one
  assign awlen = final_txn ? 8'(plan.final_len) : 8'(awm_pkg::burst_beats - 1);

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////
  // Bursts whose data started but whose address is not out yet
  awm_counter #(
    .width       ($bits(awm_pkg::txn_cnt_t)),
    .reset_value ('0)
  ) i_ahead_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (first_pulse),
    .decr       (aw_fire),
    .load_value ('0),
    .count      (),
    .is_zero    (idle)
  );

  awm_counter #(
    .width       ($bits(awm_pkg::txn_cnt_t)),
    .reset_value ('0)
  ) i_txn_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (aw_fire & ~final_txn),
    .load_value (plan.num_txn),
    .count      (),
    .is_zero    (final_txn)
  );

  a_aw_hold: assert property (
    @(posedge aclk) disable iff (areset)
    (awvalid && !awready) |=> (awvalid && $stable(awaddr))
  );

endmodule

//--- source/awm_resp_tracker.sv
// bready is tied high; every B response is taken as OKAY without looking at bresp
`include "awm_defs.svh"

module awm_resp_tracker (
  input  logic     aclk,
  input  logic     areset,
  awm_plan_if.sink plan,
  input  logic     aw_fire,
  input  logic     bvalid,
  output logic     bready,
  output logic     stall,
  output logic     ctrl_done
);

  localparam awm_pkg::outst_cnt_t max_outst = awm_pkg::outst_cnt_t'(`AWM_MAX_OUTSTANDING);

  logic bxfer;
  logic final_resp;
  awm_pkg::outst_cnt_t vacancy;

  assign bready = 1'b1;
  assign bxfer = bvalid & bready;

  // Responses still expected in this transfer
  awm_counter #(
    .width       ($bits(awm_pkg::txn_cnt_t)),
    .reset_value ('0)
  ) i_resp_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (plan.start),
    .incr       (1'b0),
    .decr       (bxfer & ~final_resp),
    .load_value (plan.num_txn),
    .count      (),
    .is_zero    (final_resp)
  );

  // Free slots for addresses in flight, no slot means stall
  awm_counter #(
    .width       ($bits(awm_pkg::outst_cnt_t)),
    .reset_value (max_outst)
  ) i_vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (bxfer),
    .decr       (aw_fire),
    .load_value ('0),
    .count      (vacancy),
    .is_zero    (stall)
  );

  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= bxfer & final_resp;
    end
  end

  // A response needs an address issued before it
  a_resp_has_addr: assert property (
    @(posedge aclk) disable iff (areset) bxfer |-> (vacancy != max_outst)
  );

endmodule

//--- source/awm_top.sv
// Stream data may arrive before start and waits in the buffer; only one transfer may run at a time
module awm_top (
  input  logic                 aclk,
  input  logic                 areset,

  // Control
  input  logic                 ctrl_start,
  output logic                 ctrl_done,
  input  awm_pkg::addr_t       ctrl_addr_offset,
  input  awm_pkg::xfer_bytes_t ctrl_xfer_bytes,

  // AXI4 write address
  output logic                 m_axi_awvalid,
  input  logic                 m_axi_awready,
  output awm_pkg::addr_t       m_axi_awaddr,
  output logic [7:0]           m_axi_awlen,

  // AXI4 write data
  output logic                 m_axi_wvalid,
  input  logic                 m_axi_wready,
  output awm_pkg::data_t       m_axi_wdata,
  output awm_pkg::strb_t       m_axi_wstrb,
  output logic                 m_axi_wlast,

  // AXI4 write response
  input  logic                 m_axi_bvalid,
  output logic                 m_axi_bready,

  // AXI4-Stream input
  input  logic                 s_axis_tvalid,
  output logic                 s_axis_tready,
  input  awm_pkg::data_t       s_axis_tdata
);

  logic fifo_full;
  logic buf_valid;
  awm_pkg::data_t buf_data;
  logic buf_pop;
  logic first_pulse;
  logic aw_fire;
  logic stall;

  awm_plan_if plan ();

  awm_request i_request (
    .aclk             (aclk),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_bytes  (ctrl_xfer_bytes),
    .plan             (plan.source)
  );

  ////////////////////////////////////////////////////////////
  // Stream side buffer
  ////////////////////////////////////////////////////////////
  assign s_axis_tready = ~fifo_full;

  awm_data_fifo i_data_fifo (
    .aclk      (aclk),
    .areset    (areset),
    .push      (s_axis_tvalid & s_axis_tready),
    .push_data (s_axis_tdata),
    .full      (fifo_full),
    .pop       (buf_pop),
    .pop_valid (buf_valid),
    .pop_data  (buf_data)
  );

  ////////////////////////////////////////////////////////////
  // AXI channel stages
  ////////////////////////////////////////////////////////////
  awm_wdata_channel i_wdata_channel (
    .aclk        (aclk),
    .areset      (areset),
    .plan        (plan.sink),
    .buf_valid   (buf_valid),
    .buf_data    (buf_data),
    .buf_pop     (buf_pop),
    .wvalid      (m_axi_wvalid),
    .wready      (m_axi_wready),
    .wdata       (m_axi_wdata),
    .wstrb       (m_axi_wstrb),
    .wlast       (m_axi_wlast),
    .first_pulse (first_pulse)
  );

  awm_addr_channel i_addr_channel (
    .aclk        (aclk),
    .areset      (areset),
    .plan        (plan.sink),
    .first_pulse (first_pulse),
    .stall       (stall),
    .awvalid     (m_axi_awvalid),
    .awready     (m_axi_awready),
    .awaddr      (m_axi_awaddr),
    .awlen       (m_axi_awlen),
    .aw_fire     (aw_fire)
  );

  awm_resp_tracker i_resp_tracker (
    .aclk      (aclk),
    .areset    (areset),
    .plan      (plan.sink),
    .aw_fire   (aw_fire),
    .bvalid    (m_axi_bvalid),
    .bready    (m_axi_bready),
    .stall     (stall),
    .ctrl_done (ctrl_done)
  );

endmodule

//--- test/awm_tb.sv
// One transfer in flight at a time; the slave answers OKAY only; stream words count up from zero
`include "awm_defs.svh"

module awm_tb;

  localparam int bytes_per_beat = `AWM_DATA_WIDTH / 8;
  // Burst length bounded by the 4 KiB boundary and the beat limit
  localparam int beats_per_burst =
      (`AWM_MAX_BURST_BYTES / bytes_per_beat < `AWM_MAX_BURST_BEATS) ?
      `AWM_MAX_BURST_BYTES / bytes_per_beat : `AWM_MAX_BURST_BEATS;
  localparam int burst_step = beats_per_burst * bytes_per_beat;
  localparam logic [`AWM_ADDR_WIDTH-1:0] addr_mask = burst_step - 1;
  localparam int done_timeout = 50000;
  localparam int fill_timeout = 200;

  logic aclk;
  logic areset;
  logic ctrl_start;
  logic ctrl_done;
  logic [`AWM_ADDR_WIDTH-1:0] ctrl_addr_offset;
  logic [`AWM_XFER_WIDTH-1:0] ctrl_xfer_bytes;
  logic m_axi_awvalid;
  logic m_axi_awready = 1'b0;
  logic [`AWM_ADDR_WIDTH-1:0] m_axi_awaddr;
  logic [7:0] m_axi_awlen;
  logic m_axi_wvalid;
  logic m_axi_wready = 1'b0;
  logic [`AWM_DATA_WIDTH-1:0] m_axi_wdata;
  logic [bytes_per_beat-1:0] m_axi_wstrb;
  logic m_axi_wlast;
  logic m_axi_bvalid = 1'b0;
  logic m_axi_bready;
  logic s_axis_tvalid = 1'b0;
  logic s_axis_tready;
  logic [`AWM_DATA_WIDTH-1:0] s_axis_tdata = '0;

  // Expected plan of the running transfer
  int error_count = 0;
  int timeout_count = 0;
  logic [`AWM_ADDR_WIDTH-1:0] exp_base = '0;
  int exp_beats = 0;
  int exp_bursts = 0;
  int exp_last_len = 0;
  logic [bytes_per_beat-1:0] exp_strb = '1;
  logic hold_responses = 1'b0;

  // Checker progress
  int aw_idx;
  int w_burst_idx;
  int beat_in_burst;
  int w_count;
  int b_idx;
  logic [`AWM_DATA_WIDTH-1:0] next_word;
  logic done_expected;
  int outstanding;

  // Slave model state
  logic [31:0] lfsr_state = 32'd66498;
  int aw_seen;
  int wlast_seen;
  int b_sent;
  logic [3:0] resp_delay;
  logic reached_limit;

  awm_top i_dut (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_done        (ctrl_done),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_bytes  (ctrl_xfer_bytes),
    .m_axi_awvalid    (m_axi_awvalid),
    .m_axi_awready    (m_axi_awready),
    .m_axi_awaddr     (m_axi_awaddr),
    .m_axi_awlen      (m_axi_awlen),
    .m_axi_wvalid     (m_axi_wvalid),
    .m_axi_wready     (m_axi_wready),
    .m_axi_wdata      (m_axi_wdata),
    .m_axi_wstrb      (m_axi_wstrb),
    .m_axi_wlast      (m_axi_wlast),
    .m_axi_bvalid     (m_axi_bvalid),
    .m_axi_bready     (m_axi_bready),
    .s_axis_tvalid    (s_axis_tvalid),
    .s_axis_tready    (s_axis_tready),
    .s_axis_tdata     (s_axis_tdata)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic report_error(input string msg);
    error_count++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ 32'h8020_0003;
    end
    return shifted;
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(input int count, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Full bursts except the last one
  function automatic int expected_len(input int idx);
    return (idx == exp_bursts - 1) ? exp_last_len : beats_per_burst - 1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stream source and memory-side slave
  ////////////////////////////////////////////////////////////
  always @(posedge aclk) begin
    if (areset) begin
      s_axis_tvalid <= 1'b0;
      s_axis_tdata <= '0;
    end else begin
      s_axis_tvalid <= 1'b1;
      if (s_axis_tvalid && s_axis_tready) begin
        s_axis_tdata <= s_axis_tdata + 1'b1;
      end
    end
  end

  always @(posedge aclk) begin
    logic [7:0] bits;
    if (areset) begin
      m_axi_awready <= 1'b0;
      m_axi_wready <= 1'b0;
      m_axi_bvalid <= 1'b0;
      aw_seen <= 0;
      wlast_seen <= 0;
      b_sent <= 0;
      resp_delay <= '0;
      reached_limit <= 1'b0;
    end else begin
      draw_bits(1, bits);
      m_axi_awready <= bits[0];
      draw_bits(1, bits);
      m_axi_wready <= bits[0];
      if (m_axi_awvalid && m_axi_awready) begin
        aw_seen <= aw_seen + 1;
      end
      if (m_axi_wvalid && m_axi_wready && m_axi_wlast) begin
        wlast_seen <= wlast_seen + 1;
      end
      if (outstanding == `AWM_MAX_OUTSTANDING) begin
        reached_limit <= 1'b1;
      end
      // Answer a burst once its address and last beat are both in
      if (m_axi_bvalid && m_axi_bready) begin
        m_axi_bvalid <= 1'b0;
        b_sent <= b_sent + 1;
        draw_bits(4, bits);
        resp_delay <= bits[3:0];
      end else if (!m_axi_bvalid && b_sent < aw_seen && b_sent < wlast_seen &&
                   !(hold_responses && !reached_limit)) begin
        if (resp_delay == '0) begin
          m_axi_bvalid <= 1'b1;
        end else begin
          resp_delay <= resp_delay - 1'b1;
        end
      end
    end
  end

  always @(posedge aclk) begin
    if (areset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(m_axi_awvalid && m_axi_awready) -
                     int'(m_axi_bvalid && m_axi_bready);
    end
  end

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////
  always @(posedge aclk) begin
    logic [`AWM_ADDR_WIDTH-1:0] expected_addr;
    logic [bytes_per_beat-1:0] expected_strb;
    if (areset) begin
      aw_idx = 0;
      w_burst_idx = 0;
      beat_in_burst = 0;
      w_count = 0;
      b_idx = 0;
      next_word = '0;
      done_expected <= 1'b0;
    end else begin
      if (ctrl_start) begin
        aw_idx = 0;
        w_burst_idx = 0;
        beat_in_burst = 0;
        w_count = 0;
        b_idx = 0;
      end
      if (m_axi_awvalid && m_axi_awready) begin
        expected_addr = exp_base + aw_idx * burst_step;
        assert (aw_idx < exp_bursts) else report_error("address beyond the last burst");
        assert (m_axi_awaddr == expected_addr)
          else report_error($sformatf("awaddr %h, expected %h", m_axi_awaddr, expected_addr));
        assert (int'(m_axi_awlen) == expected_len(aw_idx))
          else report_error($sformatf("awlen %0d, expected %0d", m_axi_awlen,
                                      expected_len(aw_idx)));
        aw_idx++;
      end
      if (m_axi_wvalid && m_axi_wready) begin
        expected_strb = (w_count == exp_beats - 1) ? exp_strb : '1;
        // Beats before start or after the final beat have no place in a transfer
        assert (w_count < exp_beats) else report_error("data beat beyond the final beat");
        assert (m_axi_wdata == next_word)
          else report_error($sformatf("wdata %h, expected %h", m_axi_wdata, next_word));
        assert (m_axi_wlast == (beat_in_burst == expected_len(w_burst_idx)))
          else report_error($sformatf("wlast %b on beat %0d of burst %0d", m_axi_wlast,
                                      beat_in_burst, w_burst_idx));
        assert (m_axi_wstrb == expected_strb)
          else report_error($sformatf("wstrb %b, expected %b", m_axi_wstrb, expected_strb));
        next_word = next_word + 1'b1;
        w_count++;
        // Burst boundaries follow the expected lengths
        if (beat_in_burst == expected_len(w_burst_idx)) begin
          beat_in_burst = 0;
          w_burst_idx++;
        end else begin
          beat_in_burst++;
        end
      end
      assert (ctrl_done == done_expected)
        else report_error($sformatf("ctrl_done %b, expected %b", ctrl_done, done_expected));
      if (ctrl_done) begin
        assert (w_count == exp_beats)
          else report_error($sformatf("%0d beats, expected %0d", w_count, exp_beats));
        assert (aw_idx == exp_bursts)
          else report_error($sformatf("%0d addresses, expected %0d", aw_idx, exp_bursts));
      end
      if (m_axi_bvalid && m_axi_bready) begin
        assert (b_idx < exp_bursts) else report_error("response beyond the last burst");
        done_expected <= (b_idx == exp_bursts - 1);
        b_idx++;
      end else begin
        done_expected <= 1'b0;
      end
    end
  end

  a_outst_limit: assert property (@(posedge aclk) disable iff (areset)
    outstanding <= `AWM_MAX_OUTSTANDING)
    else report_error($sformatf("%0d addresses outstanding", outstanding));

  // Decision for a new request uses the count of the cycle before
  a_no_aw_at_limit: assert property (@(posedge aclk) disable iff (areset)
    $rose(m_axi_awvalid) |-> $past(outstanding) < `AWM_MAX_OUTSTANDING)
    else report_error("awvalid raised at the outstanding limit");

  a_aw_hold: assert property (@(posedge aclk) disable iff (areset)
    (m_axi_awvalid && !m_axi_awready) |=> m_axi_awvalid)
    else report_error("awvalid dropped without a transfer");

  a_w_hold: assert property (@(posedge aclk) disable iff (areset)
    (m_axi_wvalid && !m_axi_wready) |=> m_axi_wvalid)
    else report_error("wvalid dropped without a transfer");

  a_bready_high: assert property (@(posedge aclk) disable iff (areset) m_axi_bready)
    else report_error("bready low");

  ////////////////////////////////////////////////////////////
  // Transfer sequence
  ////////////////////////////////////////////////////////////
  task automatic run_transfer(input logic [`AWM_ADDR_WIDTH-1:0] offset, input int bytes,
                              input logic hold, output logic timed_out);
    int cycles;
    int beats;
    int remainder;
    beats = (bytes + bytes_per_beat - 1) / bytes_per_beat;
    remainder = bytes % bytes_per_beat;
    exp_base <= offset & ~addr_mask;
    exp_beats <= beats;
    exp_bursts <= (beats + beats_per_burst - 1) / beats_per_burst;
    exp_last_len <= (beats - 1) % beats_per_burst;
    // Bytes below the remainder or all bytes for a full last beat
    exp_strb <= (remainder == 0) ? '1 : (1 << remainder) - 1;
    hold_responses <= hold;
    ctrl_addr_offset <= offset;
    ctrl_xfer_bytes <= bytes[`AWM_XFER_WIDTH-1:0];
    ctrl_start <= 1'b1;
    @(posedge aclk);
    ctrl_start <= 1'b0;
    cycles = 0;
    timed_out = 1'b0;
    while (!ctrl_done && !timed_out) begin
      @(posedge aclk);
      cycles++;
      if (cycles > done_timeout) begin
        timed_out = 1'b1;
        $display("Timeout: no ctrl_done for the %0d-byte transfer", bytes);
      end
    end
  endtask

  initial begin
    int cycles;
    logic timed_out;
    areset = 1'b1;
    ctrl_start = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_bytes = '0;
    timed_out = 1'b0;
    repeat (10) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    assert (!m_axi_awvalid && !m_axi_wvalid && !ctrl_done && s_axis_tready)
      else report_error("outputs not idle after reset");

    // Buffer fills first so early beats wait for start
    cycles = 0;
    while (s_axis_tready && !timed_out) begin
      @(posedge aclk);
      cycles++;
      if (cycles > fill_timeout) begin
        timed_out = 1'b1;
        $display("Timeout: stream buffer never filled before start");
      end
    end

    if (!timed_out) run_transfer(32'h0000_0123, 4, 1'b0, timed_out);
    if (!timed_out) run_transfer(32'h1000_0ffc, 1021, 1'b0, timed_out);
    if (!timed_out) run_transfer(32'h2345_6789, 1100, 1'b0, timed_out);
    // Nine bursts with responses held until the limit is reached
    if (!timed_out) run_transfer(32'h8000_0abc, 9000, 1'b1, timed_out);
    if (timed_out) begin
      timeout_count++;
    end

    $display("Errors: %0d failed checks, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+source
source/awm_pkg.sv
source/awm_plan_if.sv
source/awm_counter.sv
source/awm_request.sv
source/awm_data_fifo.sv
source/awm_wdata_channel.sv
source/awm_addr_channel.sv
source/awm_resp_tracker.sv
source/awm_top.sv
test/awm_tb.sv
